//--- verilog/cpu_pkg.sv
// Shared word, opcode, ALU function and field definitions imported by every pipeline stage
`default_nettype none

package cpu_pkg;

    // One data word or one instruction
    typedef logic [31:0] word_t;

    // Register number for the 32-entry register file
    typedef logic [4:0] reg_addr_t;

    // Major opcodes in bits 31 to 27
    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_jal   = 5'd3,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_t;

    // R-type function codes in bits 6 to 2
    typedef enum logic [4:0] {
        fn_add = 5'd0,
        fn_sub = 5'd1,
        fn_and = 5'd2,
        fn_or  = 5'd3,
        fn_sll = 5'd4,
        fn_sra = 5'd5
    } alu_fn_t;

    // Instruction field positions
    localparam int opcode_hi = 31;
    localparam int opcode_lo = 27;
    localparam int rd_hi = 26;
    localparam int rd_lo = 22;
    localparam int rs_hi = 21;
    localparam int rs_lo = 17;
    localparam int rt_hi = 16;
    localparam int rt_lo = 12;
    localparam int shamt_hi = 11;
    localparam int shamt_lo = 7;
    localparam int fn_hi = 6;
    localparam int fn_lo = 2;

    // Immediate and jump target both sit in the low bits
    localparam int imm_width = 17;
    localparam int target_width = 27;

    // jal writes its return address here
    localparam reg_addr_t link_reg = 5'd31;

    // All-zero word decodes as add r0, r0, r0 and changes nothing
    localparam word_t nop_word = 32'd0;

    // True for the opcodes whose result lands in rd
    function automatic logic writes_rd(input opcode_t op);
        return op inside {op_rtype, op_addi, op_lw};
    endfunction

endpackage

`default_nettype wire

//--- verilog/pipe_buses.sv
// Stage-to-stage buses for the decode/execute and execute/memory pipeline registers
`timescale 1ns/100ps
`default_nettype none

// Decode/execute register contents, written by decode and read by execute
interface dx_bus;
    import cpu_pkg::*;

    // Word address of the instruction, used for branch targets and the jal link
    word_t pc;
    word_t instr;

    // Register operands after the write-back bypass
    word_t op_a;
    word_t op_b;

    modport source (output pc, instr, op_a, op_b);
    modport sink (input pc, instr, op_a, op_b);
endinterface

// Execute/memory register contents, written by execute and read by the result stage
interface xm_bus;
    import cpu_pkg::*;

    word_t instr;

    // ALU output, or pc plus one for a jal
    word_t result;

    // Forwarded rd value, stored by sw
    word_t store_data;

    // Set for jal so that register 31 becomes the destination
    logic link;

    modport source (output instr, result, store_data, link);
    modport sink (input instr, result, store_data, link);
endinterface

`default_nettype wire

//--- verilog/alu.sv
// Combinational arithmetic, logic and shift unit used by the execute stage
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire  cpu_pkg::word_t   a,
    input  wire  cpu_pkg::word_t   b,
    input  wire  cpu_pkg::alu_fn_t fn,
    input  wire  logic [4:0]       shamt,
    output cpu_pkg::word_t         result
);
    import cpu_pkg::*;

    // Shifts act on operand A only and take their distance from the shamt field
    always_comb begin
        case (fn)
            fn_add: begin
                result = a + b;
            end
            fn_sub: begin
                result = a - b;
            end
            fn_and: begin
                result = a & b;
            end
            fn_or: begin
                result = a | b;
            end
            fn_sll: begin
                result = a << shamt;
            end
            fn_sra: begin
                result = word_t'($signed(a) >>> shamt);
            end
            // Unused function codes give zero
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
// Fetch stage holding the program counter, the j/jal redirect and the fetch/decode register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  wire             clock,
    input  wire             reset,
    input  wire  cpu_pkg::word_t q_imem,
    input  wire             stall,
    input  wire             branch_taken,
    input  wire  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t  address_imem,
    output cpu_pkg::word_t  fd_pc,
    output cpu_pkg::word_t  fd_instr
);
    import cpu_pkg::*;

    word_t   pc;
    word_t   next_pc;
    opcode_t fetch_op;
    logic    fetch_jump;

    // Instruction memory is combinational, so the pc addresses it directly
    assign address_imem = pc;

    // j and jal are spotted on the fetched word itself, so neither costs a bubble
    assign fetch_op = opcode_t'(q_imem[opcode_hi:opcode_lo]);
    assign fetch_jump = (fetch_op == op_j) || (fetch_op == op_jal);

    // A taken branch beats a stall, and a stall beats a jump
    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else if (stall) begin
            next_pc = pc;
        end else if (fetch_jump) begin
            next_pc = {{(32 - target_width){1'b0}}, q_imem[target_width-1:0]};
        end else begin
            next_pc = pc + 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    // The jump word still moves on to decode, where a jal carries on as a link instruction
    always_ff @(posedge clock) begin
        if (reset || branch_taken) begin
            fd_pc <= nop_word;
            fd_instr <= nop_word;
        end else if (!stall) begin
            fd_pc <= pc;
            fd_instr <= q_imem;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
// Decode stage with register-file read addressing, write-back bypass and load-use stall
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                 clock,
    input  wire                 reset,
    input  wire  cpu_pkg::word_t fd_pc,
    input  wire  cpu_pkg::word_t fd_instr,
    input  wire                 branch_taken,
    input  wire                 wb_enable,
    input  wire  cpu_pkg::reg_addr_t wb_reg,
    input  wire  cpu_pkg::word_t wb_data,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_a,
    output cpu_pkg::reg_addr_t  ctrl_read_reg_b,
    input  wire  cpu_pkg::word_t data_read_reg_a,
    input  wire  cpu_pkg::word_t data_read_reg_b,
    output logic                stall,
    dx_bus.source               dx
);
    import cpu_pkg::*;

    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rd;
    reg_addr_t rt;
    logic      is_rtype;
    logic      uses_a;
    logic      uses_b;
    word_t     op_a;
    word_t     op_b;
    opcode_t   ex_op;
    reg_addr_t ex_rd;

    assign op = opcode_t'(fd_instr[opcode_hi:opcode_lo]);
    assign rd = fd_instr[rd_hi:rd_lo];
    assign rs = fd_instr[rs_hi:rs_lo];
    assign rt = fd_instr[rt_hi:rt_lo];
    assign is_rtype = (op == op_rtype);

    // sw, bne and blt keep their second source in the rd field
    assign ctrl_read_reg_a = rs;
    assign ctrl_read_reg_b = is_rtype ? rt : rd;

    // Which read ports carry a real operand for this opcode
    assign uses_a = op inside {op_rtype, op_addi, op_lw, op_sw, op_bne, op_blt};
    assign uses_b = op inside {op_rtype, op_sw, op_bne, op_blt};

    // A value written back this cycle only reaches the register file at the next edge
    assign op_a = (wb_enable && wb_reg == ctrl_read_reg_a && ctrl_read_reg_a != '0) ?
                  wb_data : data_read_reg_a;
    assign op_b = (wb_enable && wb_reg == ctrl_read_reg_b && ctrl_read_reg_b != '0) ?
                  wb_data : data_read_reg_b;

    // The instruction now in execute is the one just written into the decode/execute register
    assign ex_op = opcode_t'(dx.instr[opcode_hi:opcode_lo]);
    assign ex_rd = dx.instr[rd_hi:rd_lo];

    // Load data arrives one cycle too late for execute to forward it to the next instruction
    always_comb begin
        stall = 1'b0;
        if (ex_op == op_lw && ex_rd != '0) begin
            if (uses_a && ctrl_read_reg_a == ex_rd) begin
                stall = 1'b1;
            end
            if (uses_b && ctrl_read_reg_b == ex_rd) begin
                stall = 1'b1;
            end
        end
    end

    // Operands and pc load every cycle and only the instruction word marks a bubble
    always_ff @(posedge clock) begin
        if (reset || branch_taken || stall) begin
            dx.instr <= nop_word;
        end else begin
            dx.instr <= fd_instr;
        end
        dx.pc <= fd_pc;
        dx.op_a <= op_a;
        dx.op_b <= op_b;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// Execute stage with operand forwarding, branch resolution, jal link and the execute/memory register
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                 clock,
    input  wire                 reset,
    dx_bus.sink                 dx,
    input  wire                 wb_enable,
    input  wire  cpu_pkg::reg_addr_t wb_reg,
    input  wire  cpu_pkg::word_t wb_data,
    xm_bus.source               xm,
    output logic                branch_taken,
    output cpu_pkg::word_t      branch_target
);
    import cpu_pkg::*;

    opcode_t   op;
    opcode_t   mem_op;
    reg_addr_t rs;
    reg_addr_t src_b;
    reg_addr_t mem_rd;
    logic      mem_writes;
    logic      use_imm;
    word_t     imm_ext;
    word_t     fwd_a;
    word_t     fwd_b;
    word_t     alu_b;
    word_t     alu_result;
    word_t     pc_plus_one;
    alu_fn_t   fn;

    // Picks the newest value of a source register from memory, write-back or decode
    function automatic word_t forward(input reg_addr_t src, input word_t from_dx);
        if ((mem_writes && mem_rd == src) || (xm.link && src == link_reg)) begin
            return xm.result;
        end else if (wb_enable && wb_reg == src && src != '0) begin
            return wb_data;
        end
        return from_dx;
    endfunction

    assign op = opcode_t'(dx.instr[opcode_hi:opcode_lo]);
    assign rs = dx.instr[rs_hi:rs_lo];
    assign src_b = (op == op_rtype) ? dx.instr[rt_hi:rt_lo] : dx.instr[rd_hi:rd_lo];

    // A lw in the memory stage never matches here, since decode stalls its consumer
    assign mem_op = opcode_t'(xm.instr[opcode_hi:opcode_lo]);
    assign mem_rd = xm.instr[rd_hi:rd_lo];
    assign mem_writes = writes_rd(mem_op) && mem_rd != '0;

    always_comb begin
        fwd_a = forward(rs, dx.op_a);
        fwd_b = forward(src_b, dx.op_b);
    end

    // Immediate forms replace operand B and always add
    assign imm_ext = {{(32 - imm_width){dx.instr[imm_width-1]}}, dx.instr[imm_width-1:0]};
    assign use_imm = op inside {op_addi, op_lw, op_sw};
    assign alu_b = use_imm ? imm_ext : fwd_b;
    assign fn = (op == op_rtype) ? alu_fn_t'(dx.instr[fn_hi:fn_lo]) : fn_add;

    alu u_alu (
        .a      (fwd_a),
        .b      (alu_b),
        .fn     (fn),
        .shamt  (dx.instr[shamt_hi:shamt_lo]),
        .result (alu_result)
    );

    // Branches compare rd against rs, so the port-B value is the left-hand side
    assign pc_plus_one = dx.pc + 32'd1;
    assign branch_target = pc_plus_one + imm_ext;
    assign branch_taken = (op == op_bne && fwd_b != fwd_a) ||
                          (op == op_blt && $signed(fwd_b) < $signed(fwd_a));

    always_ff @(posedge clock) begin
        if (reset) begin
            xm.instr <= nop_word;
            xm.link <= 1'b0;
        end else begin
            xm.instr <= dx.instr;
            xm.link <= (op == op_jal);
        end
        // jal returns to the word after itself
        xm.result <= (op == op_jal) ? pc_plus_one : alu_result;
        xm.store_data <= fwd_b;
    end

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
// Memory access, memory/write-back register and register-file write port of the pipeline
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  wire                 clock,
    input  wire                 reset,
    xm_bus.sink                 xm,
    input  wire  cpu_pkg::word_t q_dmem,
    output cpu_pkg::word_t      address_dmem,
    output cpu_pkg::word_t      data,
    output logic                wren,
    output logic                wb_enable,
    output cpu_pkg::reg_addr_t  wb_reg,
    output cpu_pkg::word_t      wb_data
);
    import cpu_pkg::*;

    word_t   mw_instr;
    word_t   mw_result;
    word_t   mw_loaded;
    logic    mw_link;
    opcode_t mw_op;

    // Data memory reads back in the same cycle, stores land at the next edge
    assign address_dmem = xm.result;
    assign data = xm.store_data;
    assign wren = (opcode_t'(xm.instr[opcode_hi:opcode_lo]) == op_sw);

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_instr <= nop_word;
            mw_link <= 1'b0;
        end else begin
            mw_instr <= xm.instr;
            mw_link <= xm.link;
        end
        mw_result <= xm.result;
        mw_loaded <= q_dmem;
    end

    // Writes to r0 are dropped here, which also keeps the reset nops silent
    assign mw_op = opcode_t'(mw_instr[opcode_hi:opcode_lo]);
    assign wb_reg = mw_link ? link_reg : mw_instr[rd_hi:rd_lo];
    assign wb_enable = (writes_rd(mw_op) || mw_link) && wb_reg != '0;
    assign wb_data = (mw_op == op_lw) ? mw_loaded : mw_result;

endmodule

`default_nettype wire

//--- verilog/cpu_pipeline.sv
// Top level of the five-stage core with plain instruction memory, data memory and register ports
`timescale 1ns/100ps
`default_nettype none

module cpu_pipeline #(
    parameter logic [31:0] reset_pc = 32'd0
) (
    input  wire         clock,
    input  wire         reset,
    output logic [31:0] address_imem,
    input  wire  [31:0] q_imem,
    output logic [31:0] address_dmem,
    output logic [31:0] data,
    output logic        wren,
    input  wire  [31:0] q_dmem,
    output logic        ctrl_write_enable,
    output logic [4:0]  ctrl_write_reg,
    output logic [4:0]  ctrl_read_reg_a,
    output logic [4:0]  ctrl_read_reg_b,
    output logic [31:0] data_write_reg,
    input  wire  [31:0] data_read_reg_a,
    input  wire  [31:0] data_read_reg_b
);

    wire [31:0] fd_pc;
    wire [31:0] fd_instr;
    wire        stall;
    wire        branch_taken;
    wire [31:0] branch_target;

    dx_bus dx_if ();
    xm_bus xm_if ();

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clock, .reset, .q_imem, .stall, .branch_taken, .branch_target,
        .address_imem, .fd_pc, .fd_instr
    );

    // The register-file write port doubles as the write-back bypass into decode and execute
    decode_stage u_decode (
        .clock, .reset, .fd_pc, .fd_instr, .branch_taken,
        .wb_enable(ctrl_write_enable), .wb_reg(ctrl_write_reg), .wb_data(data_write_reg),
        .ctrl_read_reg_a, .ctrl_read_reg_b, .data_read_reg_a, .data_read_reg_b,
        .stall, .dx(dx_if.source)
    );

    execute_stage u_execute (
        .clock, .reset, .dx(dx_if.sink),
        .wb_enable(ctrl_write_enable), .wb_reg(ctrl_write_reg), .wb_data(data_write_reg),
        .xm(xm_if.source), .branch_taken, .branch_target
    );

    result_stage u_result (
        .clock, .reset, .xm(xm_if.sink), .q_dmem, .address_dmem, .data, .wren,
        .wb_enable(ctrl_write_enable), .wb_reg(ctrl_write_reg), .wb_data(data_write_reg)
    );

endmodule

`default_nettype wire

//--- verification/cpu_program.svh
// Test program for the pipeline testbench with its expected register writes and stores
`ifndef cpu_program_svh
`define cpu_program_svh

// Opcodes and R-type function codes of the instruction set
localparam logic [4:0] op_j = 5'd1;
localparam logic [4:0] op_bne = 5'd2;
localparam logic [4:0] op_jal = 5'd3;
localparam logic [4:0] op_addi = 5'd5;
localparam logic [4:0] op_blt = 5'd6;
localparam logic [4:0] op_sw = 5'd7;
localparam logic [4:0] op_lw = 5'd8;
localparam logic [4:0] fn_add = 5'd0;
localparam logic [4:0] fn_sub = 5'd1;
localparam logic [4:0] fn_and = 5'd2;
localparam logic [4:0] fn_or = 5'd3;
localparam logic [4:0] fn_sll = 5'd4;
localparam logic [4:0] fn_sra = 5'd5;

localparam int prog_len = 34;

logic [31:0] program_rom [prog_len];
string       write_name [$];
logic [4:0]  write_reg [$];
logic [31:0] write_value [$];
string       store_name [$];
logic [31:0] store_addr [$];
logic [31:0] store_value [$];

// R-type layout is opcode, rd, rs, rt, shamt, function and two spare bits
function automatic logic [31:0] rtype_word(input int rd, input int rs, input int rt,
                                           input int shamt, input logic [4:0] fn);
    return {5'd0, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], fn, 2'b00};
endfunction

// addi, lw, sw, bne and blt all carry a 17-bit immediate below rs
function automatic logic [31:0] imm_word(input logic [4:0] op, input int rd, input int rs,
                                         input int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
    return {op, target[26:0]};
endfunction

task automatic push_write(input string name, input int rd, input logic [31:0] value);
    write_name.push_back(name);
    write_reg.push_back(rd[4:0]);
    write_value.push_back(value);
endtask

task automatic push_store(input string name, input logic [31:0] addr,
                          input logic [31:0] value);
    store_name.push_back(name);
    store_addr.push_back(addr);
    store_value.push_back(value);
endtask

task automatic build_tables();
    // Constants and one of each ALU function
    program_rom[0] = imm_word(op_addi, 1, 0, 12);
    program_rom[1] = imm_word(op_addi, 2, 0, 5);
    program_rom[2] = imm_word(op_addi, 3, 0, -8);
    program_rom[3] = rtype_word(4, 1, 2, 0, fn_add);
    program_rom[4] = rtype_word(5, 1, 2, 0, fn_sub);
    program_rom[5] = rtype_word(6, 1, 2, 0, fn_and);
    program_rom[6] = rtype_word(7, 1, 2, 0, fn_or);
    program_rom[7] = rtype_word(8, 2, 0, 3, fn_sll);
    program_rom[8] = rtype_word(9, 3, 0, 2, fn_sra);
    // Dependence distances of one, two and three instructions
    program_rom[9] = imm_word(op_addi, 10, 0, 100);
    program_rom[10] = rtype_word(11, 10, 10, 0, fn_add);
    program_rom[11] = rtype_word(12, 11, 10, 0, fn_add);
    program_rom[12] = rtype_word(13, 12, 10, 0, fn_sub);
    // Store, load it back, then use the loaded register at once
    program_rom[13] = imm_word(op_addi, 14, 0, 40);
    program_rom[14] = imm_word(op_sw, 12, 14, 3);
    program_rom[15] = imm_word(op_lw, 15, 14, 3);
    program_rom[16] = rtype_word(16, 15, 1, 0, fn_add);
    program_rom[17] = imm_word(op_sw, 15, 14, 4);
    // Taken bne over two planted writes, then a bne that falls through
    program_rom[18] = imm_word(op_bne, 1, 2, 2);
    program_rom[19] = imm_word(op_addi, 20, 0, 1);
    program_rom[20] = imm_word(op_addi, 21, 0, 2);
    program_rom[21] = imm_word(op_bne, 1, 1, 1);
    program_rom[22] = imm_word(op_addi, 17, 0, 7);
    // Same pattern for blt, with the negative value in rd
    program_rom[23] = imm_word(op_blt, 3, 1, 2);
    program_rom[24] = imm_word(op_addi, 20, 0, 3);
    program_rom[25] = imm_word(op_addi, 21, 0, 4);
    program_rom[26] = imm_word(op_blt, 1, 3, 1);
    program_rom[27] = imm_word(op_addi, 18, 0, 9);
    // j over one word, jal over one word, then read the link register
    program_rom[28] = jump_word(op_j, 30);
    program_rom[29] = imm_word(op_addi, 20, 0, 5);
    program_rom[30] = jump_word(op_jal, 32);
    program_rom[31] = imm_word(op_addi, 21, 0, 6);
    program_rom[32] = rtype_word(19, 31, 0, 0, fn_add);
    program_rom[33] = jump_word(op_j, 33);

    push_write("alu_addi_pos", 1, 32'h0000000c);
    push_write("alu_addi_small", 2, 32'h00000005);
    push_write("alu_addi_neg", 3, 32'hfffffff8);
    push_write("alu_add", 4, 32'h00000011);
    push_write("alu_sub", 5, 32'h00000007);
    push_write("alu_and", 6, 32'h00000004);
    push_write("alu_or", 7, 32'h0000000d);
    push_write("alu_sll", 8, 32'h00000028);
    push_write("alu_sra", 9, 32'hfffffffe);
    push_write("fwd_base", 10, 32'h00000064);
    push_write("fwd_one_back", 11, 32'h000000c8);
    push_write("fwd_two_back", 12, 32'h0000012c);
    push_write("fwd_decode_bypass", 13, 32'h000000c8);
    push_write("load_base_addr", 14, 32'h00000028);
    push_write("load_word", 15, 32'h0000012c);
    push_write("load_use_add", 16, 32'h00000138);
    push_write("bne_fall_through", 17, 32'h00000007);
    push_write("blt_fall_through", 18, 32'h00000009);
    push_write("jal_link", 31, 32'h0000001f);
    push_write("jal_link_forward", 19, 32'h0000001f);

    push_store("store_before_load", 32'd43, 32'h0000012c);
    push_store("store_loaded_value", 32'd44, 32'h0000012c);
endtask

`endif

//--- verification/cpu_tb.sv
// Self-checking testbench that runs the test program on the pipeline and checks every write
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    localparam int drive_delay = 1;
    localparam int drain_cycles = 6;

    logic        clock;
    logic        reset;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;
    logic        ctrl_write_enable;
    logic [4:0]  ctrl_write_reg;
    logic [4:0]  ctrl_read_reg_a;
    logic [4:0]  ctrl_read_reg_b;
    logic [31:0] data_write_reg;
    logic [31:0] data_read_reg_a;
    logic [31:0] data_read_reg_b;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] regs [32];
    int          write_index = 0;
    int          store_index = 0;
    int          cycle_count = 0;

    `include "cpu_program.svh"

    // Each instruction needs at most a few cycles, plus pipeline fill and reset
    localparam int cycle_limit = 4 * prog_len + 20;

    cpu_pipeline u_dut (
        .clock(clock), .reset(reset),
        .address_imem(address_imem), .q_imem(q_imem),
        .address_dmem(address_dmem), .data(data), .wren(wren), .q_dmem(q_dmem),
        .ctrl_write_enable(ctrl_write_enable), .ctrl_write_reg(ctrl_write_reg),
        .ctrl_read_reg_a(ctrl_read_reg_a), .ctrl_read_reg_b(ctrl_read_reg_b),
        .data_write_reg(data_write_reg),
        .data_read_reg_a(data_read_reg_a), .data_read_reg_b(data_read_reg_b)
    );

    // Memories and register file answer reads combinationally
    // Fetches past the end of the program read as nops
    assign q_imem = (address_imem < prog_len) ? imem[address_imem[5:0]] : '0;
    assign q_dmem = dmem[address_dmem[5:0]];
    assign data_read_reg_a = (ctrl_read_reg_a == 5'd0) ? '0 : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == 5'd0) ? '0 : regs[ctrl_read_reg_b];

    // Register file and data memory get an address-dependent fill during reset
    // Afterwards writes land at the rising edge like the real memories
    always @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k[4:0]] <= 32'h5a000000 + k;
            end
            for (int k = 0; k < 64; k++) begin
                dmem[k[5:0]] <= 32'h0d000000 + k;
            end
        end else begin
            if (ctrl_write_enable) begin
                regs[ctrl_write_reg] <= data_write_reg;
            end
            if (wren) begin
                dmem[address_dmem[5:0]] <= data;
            end
        end
    end

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("Test FAILED");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic tables_done();
        return write_index >= write_name.size() && store_index >= store_name.size();
    endfunction

    // Each register write must be the next entry of the write table
    task automatic check_write();
        int idx;
        idx = write_index;
        write_index++;
        if (idx >= write_name.size()) begin
            $display("Register r%0d was written after the last expected write", ctrl_write_reg);
            abort_run("unexpected register write");
        end else begin
            assert (ctrl_write_reg == write_reg[idx] && data_write_reg == write_value[idx])
            else begin
                $display("ERROR %s: expected r%0d = 0x%08h, actual r%0d = 0x%08h",
                         write_name[idx], write_reg[idx], write_value[idx],
                         ctrl_write_reg, data_write_reg);
                abort_run("register write mismatch");
            end
        end
    endtask

    task automatic check_store();
        int idx;
        idx = store_index;
        store_index++;
        if (idx >= store_name.size()) begin
            $display("Data memory was written at %0d after the last expected store", address_dmem);
            abort_run("unexpected store");
        end else begin
            assert (address_dmem == store_addr[idx] && data == store_value[idx]) else begin
                $display("ERROR %s: expected mem[%0d] = 0x%08h, actual mem[%0d] = 0x%08h",
                         store_name[idx], store_addr[idx], store_value[idx],
                         address_dmem, data);
                abort_run("store mismatch");
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clock) begin
        if (!reset && ctrl_write_enable) begin
            check_write();
        end
    end

    always @(negedge clock) begin
        if (!reset && wren) begin
            check_store();
        end
    end

    initial begin
        int i;
        reset = 1'b1;
        build_tables();
        for (i = 0; i < prog_len; i++) begin
            imem[i[5:0]] = program_rom[i[5:0]];
        end

        repeat (2) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        while (!tables_done() && cycle_count < cycle_limit) begin
            @(posedge clock);
        end
        if (tables_done()) begin
            // The closing jump loop must stay silent
            repeat (drain_cycles) @(posedge clock);
            $display("Test OK");
            $finish;
        end else begin
            $display("The program did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
verilog/cpu_pkg.sv
verilog/pipe_buses.sv
verilog/alu.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/cpu_pipeline.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the pipeline testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module cpu_tb -Mdir obj_dir \
    && ./obj_dir/Vcpu_tb | tee sim.log \
    || echo "Build or simulation ended with an error"
grep -qs "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
